// File: include/game_defs.svh
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// horizontal timing defaults, 1024x768 at 60 Hz
`define GAME_H_ACTIVE   1024
`define GAME_H_FRONT    24
`define GAME_H_SYNC     136
`define GAME_H_BACK     160

// vertical timing defaults, counted in lines
`define GAME_V_ACTIVE   768
`define GAME_V_FRONT    3
`define GAME_V_SYNC     6
`define GAME_V_BACK     29

// background picture index per scene
// each index selects one full frame in the picture store
`define GAME_BG_START   3'd0
`define GAME_BG_LEVEL1  3'd1
`define GAME_BG_LEVEL2  3'd2
`define GAME_BG_LEVEL3  3'd3
`define GAME_BG_PAUSE   3'd4
`define GAME_BG_OVER    3'd5
`define GAME_BG_METHOD  3'd6
`define GAME_BG_WIN     3'd7

`endif

// File: project.f
+incdir+include
verilog/game_pkg.sv
verilog/scene_ctrl.sv
verilog/video_timing.sv
verilog/frame_fetch.sv
verilog/pixel_out.sv
verilog/game_top.sv
tests/tb_game_top.sv

// File: tests/tb_game_top.sv
`include "game_defs.svh"

module tb_game_top;

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    localparam int H_ACT        = 16;
    localparam int V_ACT        = 8;
    localparam int H_FP         = 2;        // porches and sync width in pixels
    localparam int H_SW         = 2;
    localparam int H_BP         = 2;
    localparam int V_FP         = 1;        // same in lines
    localparam int V_SW         = 1;
    localparam int V_BP         = 1;
    localparam int H_TOTAL      = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOTAL      = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME_PIX    = H_ACT * V_ACT;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam logic [31:0] SEED = 32'h89156c15;

    // masks in struct member order, first member is the msb
    localparam buttons_t     B_NONE    = 10'b00_0000_0000;
    localparam buttons_t     B_START   = 10'b10_0000_0000;
    localparam buttons_t     B_PAUSE   = 10'b01_0000_0000;
    localparam buttons_t     B_RESUME  = 10'b00_1000_0000;
    localparam buttons_t     B_RESTART = 10'b00_0100_0000;
    localparam buttons_t     B_METHOD  = 10'b00_0010_0000;
    localparam buttons_t     B_CANCEL  = 10'b00_0001_0000;
    localparam buttons_t     B_LEVEL1  = 10'b00_0000_1000;
    localparam buttons_t     B_LEVEL2  = 10'b00_0000_0100;
    localparam buttons_t     B_LEVEL3  = 10'b00_0000_0010;
    localparam buttons_t     B_EXIT    = 10'b00_0000_0001;
    localparam game_events_t E_NONE    = 4'b0000;
    localparam game_events_t E_DEAD    = 4'b1000;
    localparam game_events_t E_LEVEL2  = 4'b0100;
    localparam game_events_t E_LEVEL3  = 4'b0010;
    localparam game_events_t E_WON     = 4'b0001;

    // background index per scene, in enum order
    localparam bg_index_t BG_OF [8] = '{`GAME_BG_START, `GAME_BG_LEVEL1, `GAME_BG_LEVEL2,
        `GAME_BG_LEVEL3, `GAME_BG_PAUSE, `GAME_BG_OVER, `GAME_BG_METHOD, `GAME_BG_WIN};

    logic         clk_hdmi;
    logic         rst_n;
    buttons_t     buttons;
    game_events_t events;
    rgb565_t      bg_pixel;
    scene_code_t  state_number;
    logic         bg_rd_en;
    frame_addr_t  bg_rd_addr;
    rgb888_t      lcd_data;
    logic         lcd_de;
    logic         lcd_hs;
    logic         lcd_vs;

    scene_t       model_scene;
    scene_t       prev_scene;      // scene one cycle back, seen by frame_start
    scene_t       saved_level;
    frame_addr_t  frame_base;
    frame_addr_t  pending [$];     // reads not yet on screen
    int           rd_count;
    int           de_count;
    int           frames_done;
    int           pos_cnt;         // cycles since reset release
    logic         prev_vs;

    game_top #(
        .H_ACTIVE (H_ACT), .H_FRONT (H_FP), .H_SYNC (H_SW), .H_BACK (H_BP),
        .V_ACTIVE (V_ACT), .V_FRONT (V_FP), .V_SYNC (V_SW), .V_BACK (V_BP)
    ) u_game_top (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic rgb565_t store_word(input frame_addr_t a);
        return rgb565_t'(xorshift32(SEED ^ 32'(a)));
    endfunction

    // {de, hs, vs} for an output that trails the raw counters by lag cycles
    function automatic logic [2:0] video_levels(input int c, input int lag);
        int r;
        int h;
        int v;
        r = c - lag;
        if (r < 0)
            return 3'b011;                              // idle before the first count
        h = r % H_TOTAL;
        v = (r / H_TOTAL) % V_TOTAL;
        return {h < H_ACT && v < V_ACT,
                !(h >= H_ACT + H_FP && h < H_ACT + H_FP + H_SW),
                !(v >= V_ACT + V_FP && v < V_ACT + V_FP + V_SW)};
    endfunction

    function automatic scene_t next_scene(input scene_t cur, input scene_t saved,
                                          input buttons_t b, input game_events_t e);
        scene_t nxt;
        nxt = cur;
        case (cur)
            scene_level1, scene_level2, scene_level3: begin
                if (b.exit) nxt = scene_start;
                else if (b.pause) nxt = scene_pause;
                else if (e.all_dead) nxt = scene_gameover;
                else if (cur == scene_level1 && e.level2_reached) nxt = scene_level2;
                else if (cur == scene_level2 && e.level3_reached) nxt = scene_level3;
                else if (cur == scene_level3 && e.won) nxt = scene_win;
            end
            scene_start: begin
                if (b.start || b.level1) nxt = scene_level1;
                else if (b.level2) nxt = scene_level2;
                else if (b.level3) nxt = scene_level3;
                else if (b.method) nxt = scene_method;
            end
            scene_method: if (b.cancel) nxt = scene_start;
            scene_pause: begin
                if (b.resume) nxt = saved;
                else if (b.restart) nxt = scene_start;
            end
            default: if (b.restart) nxt = scene_start;     // gameover and win
        endcase
        return nxt;
    endfunction

    function automatic scene_code_t code_of(input scene_t s);
        if (s == scene_win) return '1;
        return scene_code_t'(1) << s;
    endfunction

    function automatic rgb888_t widen(input rgb565_t w);
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
        r = w[15:11];
        g = w[10:5];
        b = w[4:0];
        return {r, r[4:2], g, g[5:4], b, b[4:2]};
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_code(input string name, input scene_code_t exp, input scene_code_t act);
        if (act !== exp)
            stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_addr(input string name, input frame_addr_t exp, input frame_addr_t act);
        if (act !== exp)
            stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic check_color(input string name, input rgb888_t exp, input rgb888_t act);
        if (act !== exp)
            stop_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("FAILED %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp)
            stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
    endtask

    task automatic press(input string name, input buttons_t b, input game_events_t e,
                         input scene_t exp);
        @(posedge clk_hdmi);
        buttons <= b;
        events  <= e;
        @(posedge clk_hdmi);
        buttons <= B_NONE;
        events  <= E_NONE;
        @(negedge clk_hdmi);
        check_code(name, code_of(exp), state_number);
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = frames_done + n;
        cycles = 0;
        while (frames_done < target) begin
            @(posedge clk_hdmi);
            cycles++;
            if (cycles > 2 * n * FRAME_CYCLES)
                stop_run("timed out waiting for the end of a frame");
        end
    endtask

    task automatic wait_pixel(input int n);
        int cycles;
        cycles = 0;
        while (rd_count != n) begin
            @(posedge clk_hdmi);
            cycles++;
            if (cycles > 2 * FRAME_CYCLES)
                stop_run("timed out waiting for a pixel in the middle of a frame");
        end
    endtask

    initial begin
        clk_hdmi = 1'b0;
        forever #4 clk_hdmi = ~clk_hdmi;
    end

    // picture store, one cycle read latency
    always @(posedge clk_hdmi) begin
        if (bg_rd_en === 1'b1)
            bg_pixel <= store_word(bg_rd_addr);
    end

    always @(negedge clk_hdmi) begin : compare_outputs
        scene_t      nxt;
        frame_addr_t exp_addr;
        logic [2:0]  exp_lv;
        if (rst_n !== 1'b1) begin
            model_scene = scene_start;
            prev_scene  = scene_start;
            saved_level = scene_level1;
            rd_count    = 0;
            de_count    = 0;
            pos_cnt     = 0;
            prev_vs     = 1'b1;
            pending.delete();
        end else begin
            check_code("scene code", code_of(model_scene), state_number);
            exp_lv = video_levels(pos_cnt, 2);              // one stage after the counters
            check_level("bg_rd_en", exp_lv[2], bg_rd_en);
            exp_lv = video_levels(pos_cnt, 4);              // three stages after the counters
            check_level("lcd_de", exp_lv[2], lcd_de);
            check_level("lcd_hs", exp_lv[1], lcd_hs);
            check_level("lcd_vs", exp_lv[0], lcd_vs);
            if (bg_rd_en === 1'b1) begin
                if (rd_count == 0)
                    frame_base = frame_addr_t'(BG_OF[prev_scene]) * FRAME_PIX;
                exp_addr = frame_base + frame_addr_t'(rd_count);   // raster order y*16+x
                check_addr("read address", exp_addr, bg_rd_addr);
                pending.push_back(exp_addr);
                rd_count++;
            end
            if (lcd_de === 1'b1) begin
                if (pending.size() == 0)
                    stop_run("lcd_de went high with no read outstanding");
                check_color("pixel color", widen(store_word(pending.pop_front())), lcd_data);
                de_count++;
            end else begin
                check_color("blank color", '0, lcd_data);
            end
            if (prev_vs && !lcd_vs) begin         // vsync start closes the frame
                check_count("reads per frame", FRAME_PIX, rd_count);
                check_count("de cycles per frame", FRAME_PIX, de_count);
                rd_count = 0;
                de_count = 0;
                frames_done++;
            end
            prev_vs = lcd_vs;
            nxt = next_scene(model_scene, saved_level, buttons, events);
            if (nxt == scene_pause && model_scene != scene_pause)
                saved_level = model_scene;
            prev_scene  = model_scene;
            model_scene = nxt;
            pos_cnt++;
        end
    end

    initial begin
        rst_n       = 1'b0;
        buttons     = B_NONE;
        events      = E_NONE;
        bg_pixel    = '0;
        frames_done = 0;
        repeat (16) @(posedge clk_hdmi);
        rst_n <= 1'b1;
        @(negedge clk_hdmi);
        check_code("reset scene", code_of(scene_start), state_number);
        check_level("reset bg_rd_en", 1'b0, bg_rd_en);
        check_level("reset lcd_de", 1'b0, lcd_de);
        wait_frames(1);
        press("start to level1", B_START, E_NONE, scene_level1);
        wait_frames(1);
        press("pause level1", B_PAUSE, E_NONE, scene_pause);
        press("resume level1", B_RESUME, E_NONE, scene_level1);
        press("reach level2", B_NONE, E_LEVEL2, scene_level2);
        press("reach level3", B_NONE, E_LEVEL3, scene_level3);
        wait_frames(1);
        press("win", B_NONE, E_WON, scene_win);
        wait_frames(1);
        press("restart from win", B_RESTART, E_NONE, scene_start);
        press("method", B_METHOD, E_NONE, scene_method);
        wait_frames(1);
        press("cancel", B_CANCEL, E_NONE, scene_start);
        press("level1 button", B_LEVEL1, E_NONE, scene_level1);
        press("exit priority", B_EXIT | B_PAUSE, E_DEAD, scene_start);
        press("level2 button", B_LEVEL2, E_NONE, scene_level2);
        press("pause over all_dead", B_PAUSE, E_DEAD | E_LEVEL3, scene_pause);
        wait_frames(1);
        press("resume level2", B_RESUME, E_NONE, scene_level2);
        press("all_dead over level3", B_NONE, E_DEAD | E_LEVEL3, scene_gameover);
        wait_frames(1);
        press("restart from gameover", B_RESTART, E_NONE, scene_start);
        press("level3 button", B_LEVEL3, E_NONE, scene_level3);
        press("pause level3", B_PAUSE, E_NONE, scene_pause);
        press("resume level3", B_RESUME, E_NONE, scene_level3);
        press("pause level3 again", B_PAUSE, E_NONE, scene_pause);
        press("restart from pause", B_RESTART, E_NONE, scene_start);
        wait_pixel(FRAME_PIX / 2);
        press("mid-frame level1", B_LEVEL1, E_NONE, scene_level1);
        wait_frames(2);
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog/frame_fetch.sv
`include "game_defs.svh"

module frame_fetch #(
    parameter int H_ACTIVE = `GAME_H_ACTIVE,
    parameter int V_ACTIVE = `GAME_V_ACTIVE
) (
    input  logic                  clk_hdmi,
    input  logic                  rst_n,
    input  game_pkg::scene_t      scene,
    input  game_pkg::video_pos_t  vpos,
    output logic                  bg_rd_en,
    output game_pkg::frame_addr_t bg_rd_addr
);

    import game_pkg::*;

    localparam frame_addr_t LINE_WORDS  = frame_addr_t'(H_ACTIVE);
    localparam frame_addr_t FRAME_WORDS = frame_addr_t'(H_ACTIVE * V_ACTIVE);

    frame_addr_t base_q;        // background of the current frame
    frame_addr_t base_cur;
    frame_addr_t pixel_offset;

    function automatic bg_index_t scene_bg(input scene_t s);
        case (s)
            scene_start:    return `GAME_BG_START;
            scene_level1:   return `GAME_BG_LEVEL1;
            scene_level2:   return `GAME_BG_LEVEL2;
            scene_level3:   return `GAME_BG_LEVEL3;
            scene_pause:    return `GAME_BG_PAUSE;
            scene_gameover: return `GAME_BG_OVER;
            scene_method:   return `GAME_BG_METHOD;
            default:        return `GAME_BG_WIN;
        endcase
    endfunction

    // the frame_start pixel already uses the freshly latched base
    assign base_cur = vpos.frame_start ? frame_addr_t'(scene_bg(scene)) * FRAME_WORDS
                                       : base_q;
    assign pixel_offset = frame_addr_t'(vpos.y) * LINE_WORDS + frame_addr_t'(vpos.x);

    always_ff @(posedge clk_hdmi) begin
        if (vpos.frame_start) begin
            base_q <= base_cur;         // scene changes mid-frame wait for next frame
        end
        bg_rd_addr <= base_cur + pixel_offset;
    end

    always_ff @(posedge clk_hdmi) begin
        if (!rst_n) begin
            bg_rd_en <= 1'b0;
        end else begin
            bg_rd_en <= vpos.de;        // one read per active pixel
        end
    end

endmodule

// File: verilog/game_pkg.sv
package game_pkg;

    typedef enum logic [2:0] {
        scene_start,
        scene_level1,
        scene_level2,
        scene_level3,
        scene_pause,
        scene_gameover,
        scene_method,
        scene_win
    } scene_t;

    typedef logic [6:0]  scene_code_t;     // one-hot, win is all ones
    typedef logic [10:0] pos_t;            // active-area coordinate
    typedef logic [11:0] cnt_t;            // raw h/v counter
    typedef logic [22:0] frame_addr_t;     // picture-store word address
    typedef logic [2:0]  bg_index_t;
    typedef logic [15:0] rgb565_t;
    typedef logic [23:0] rgb888_t;

    typedef struct packed {
        logic start;
        logic pause;
        logic resume;
        logic restart;
        logic method;
        logic cancel;
        logic level1;
        logic level2;
        logic level3;
        logic exit;
    } buttons_t;

    typedef struct packed {
        logic all_dead;
        logic level2_reached;
        logic level3_reached;
        logic won;
    } game_events_t;

    typedef struct packed {
        logic de;
        logic hs;               // active low
        logic vs;               // active low
        logic frame_start;      // x=0, y=0 only
        pos_t x;
        pos_t y;
    } video_pos_t;

endpackage

// File: verilog/game_top.sv
`include "game_defs.svh"

module game_top #(
    parameter int H_ACTIVE = `GAME_H_ACTIVE,
    parameter int H_FRONT  = `GAME_H_FRONT,
    parameter int H_SYNC   = `GAME_H_SYNC,
    parameter int H_BACK   = `GAME_H_BACK,
    parameter int V_ACTIVE = `GAME_V_ACTIVE,
    parameter int V_FRONT  = `GAME_V_FRONT,
    parameter int V_SYNC   = `GAME_V_SYNC,
    parameter int V_BACK   = `GAME_V_BACK
) (
    input  logic                   clk_hdmi,
    input  logic                   rst_n,
    input  game_pkg::buttons_t     buttons,
    input  game_pkg::game_events_t events,
    input  game_pkg::rgb565_t      bg_pixel,     // one cycle after bg_rd_en
    output game_pkg::scene_code_t  state_number,
    output logic                   bg_rd_en,
    output game_pkg::frame_addr_t  bg_rd_addr,
    output game_pkg::rgb888_t      lcd_data,
    output logic                   lcd_de,
    output logic                   lcd_hs,
    output logic                   lcd_vs
);

    import game_pkg::*;

    scene_t     scene;
    video_pos_t vpos;

    scene_ctrl u_scene_ctrl (
        .clk_hdmi     (clk_hdmi),
        .rst_n        (rst_n),
        .buttons      (buttons),
        .events       (events),
        .scene        (scene),
        .state_number (state_number)
    );

    video_timing #(
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) u_video_timing (
        .clk_hdmi (clk_hdmi),
        .rst_n    (rst_n),
        .vpos     (vpos)
    );

    frame_fetch #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_frame_fetch (
        .clk_hdmi   (clk_hdmi),
        .rst_n      (rst_n),
        .scene      (scene),
        .vpos       (vpos),
        .bg_rd_en   (bg_rd_en),
        .bg_rd_addr (bg_rd_addr)
    );

    pixel_out u_pixel_out (
        .clk_hdmi (clk_hdmi),
        .rst_n    (rst_n),
        .vpos     (vpos),
        .bg_pixel (bg_pixel),
        .lcd_data (lcd_data),
        .lcd_de   (lcd_de),
        .lcd_hs   (lcd_hs),
        .lcd_vs   (lcd_vs)
    );

endmodule

// File: verilog/pixel_out.sv
module pixel_out (
    input  logic                 clk_hdmi,
    input  logic                 rst_n,
    input  game_pkg::video_pos_t vpos,
    input  game_pkg::rgb565_t    bg_pixel,
    output game_pkg::rgb888_t    lcd_data,
    output logic                 lcd_de,
    output logic                 lcd_hs,
    output logic                 lcd_vs
);

    import game_pkg::*;

    logic [2:0] de_d;           // [1] lines up with bg_pixel
    logic [2:0] hs_d;
    logic [2:0] vs_d;
    rgb888_t    widened;

    // repeat the top bits so full scale maps to 8'hff
    assign widened = {bg_pixel[15:11], bg_pixel[15:13],
                      bg_pixel[10:5],  bg_pixel[10:9],
                      bg_pixel[4:0],   bg_pixel[4:2]};

    always_ff @(posedge clk_hdmi) begin
        if (!rst_n) begin
            de_d     <= '0;
            hs_d     <= '1;         // syncs idle high
            vs_d     <= '1;
            lcd_data <= '0;
        end else begin
            de_d     <= {de_d[1:0], vpos.de};
            hs_d     <= {hs_d[1:0], vpos.hs};
            vs_d     <= {vs_d[1:0], vpos.vs};
            lcd_data <= de_d[1] ? widened : '0;     // blank outside active area
        end
    end

    assign lcd_de = de_d[2];
    assign lcd_hs = hs_d[2];
    assign lcd_vs = vs_d[2];

endmodule

// File: verilog/scene_ctrl.sv
module scene_ctrl (
    input  logic                   clk_hdmi,
    input  logic                   rst_n,
    input  game_pkg::buttons_t     buttons,
    input  game_pkg::game_events_t events,
    output game_pkg::scene_t       scene,
    output game_pkg::scene_code_t  state_number
);

    import game_pkg::*;

    localparam scene_code_t CODE_START    = 7'b0000001;
    localparam scene_code_t CODE_LEVEL1   = 7'b0000010;
    localparam scene_code_t CODE_LEVEL2   = 7'b0000100;
    localparam scene_code_t CODE_LEVEL3   = 7'b0001000;
    localparam scene_code_t CODE_PAUSE    = 7'b0010000;
    localparam scene_code_t CODE_GAMEOVER = 7'b0100000;
    localparam scene_code_t CODE_METHOD   = 7'b1000000;
    localparam scene_code_t CODE_WIN      = 7'b1111111;

    scene_t scene_next;
    scene_t saved_level;        // level to return to from pause
    scene_t saved_next;

    function automatic scene_code_t scene_code(input scene_t s);
        case (s)
            scene_start:    return CODE_START;
            scene_level1:   return CODE_LEVEL1;
            scene_level2:   return CODE_LEVEL2;
            scene_level3:   return CODE_LEVEL3;
            scene_pause:    return CODE_PAUSE;
            scene_gameover: return CODE_GAMEOVER;
            scene_method:   return CODE_METHOD;
            default:        return CODE_WIN;
        endcase
    endfunction

    always_comb begin
        scene_next = scene;
        saved_next = saved_level;
        case (scene)
            scene_level1, scene_level2, scene_level3: begin
                if (buttons.exit) begin
                    scene_next = scene_start;
                end else if (buttons.pause) begin
                    saved_next = scene;                     // remember where we left
                    scene_next = scene_pause;
                end else if (events.all_dead) begin
                    scene_next = scene_gameover;
                end else if (scene == scene_level1 && events.level2_reached) begin
                    scene_next = scene_level2;
                end else if (scene == scene_level2 && events.level3_reached) begin
                    scene_next = scene_level3;
                end else if (scene == scene_level3 && events.won) begin
                    scene_next = scene_win;
                end
            end
            scene_start: begin
                if (buttons.start || buttons.level1) begin
                    scene_next = scene_level1;
                end else if (buttons.level2) begin
                    scene_next = scene_level2;
                end else if (buttons.level3) begin
                    scene_next = scene_level3;
                end else if (buttons.method) begin
                    scene_next = scene_method;
                end
            end
            scene_method: begin
                if (buttons.cancel) begin
                    scene_next = scene_start;
                end
            end
            scene_pause: begin
                if (buttons.resume) begin
                    scene_next = saved_level;
                end else if (buttons.restart) begin
                    scene_next = scene_start;
                end
            end
            default: begin                                  // gameover and win
                if (buttons.restart) begin
                    scene_next = scene_start;
                end
            end
        endcase
    end

    always_ff @(posedge clk_hdmi) begin
        if (!rst_n) begin
            scene        <= scene_start;
            saved_level  <= scene_level1;
            state_number <= CODE_START;
        end else begin
            scene        <= scene_next;
            saved_level  <= saved_next;
            state_number <= scene_code(scene_next);        // code tracks the scene register
        end
    end

endmodule

// File: verilog/video_timing.sv
`include "game_defs.svh"

module video_timing #(
    parameter int H_ACTIVE = `GAME_H_ACTIVE,
    parameter int H_FRONT  = `GAME_H_FRONT,
    parameter int H_SYNC   = `GAME_H_SYNC,
    parameter int H_BACK   = `GAME_H_BACK,
    parameter int V_ACTIVE = `GAME_V_ACTIVE,
    parameter int V_FRONT  = `GAME_V_FRONT,
    parameter int V_SYNC   = `GAME_V_SYNC,
    parameter int V_BACK   = `GAME_V_BACK
) (
    input  logic                 clk_hdmi,
    input  logic                 rst_n,
    output game_pkg::video_pos_t vpos
);

    import game_pkg::*;

    // sync interval follows active area and front porch
    localparam cnt_t H_SYNC_BEG = cnt_t'(H_ACTIVE + H_FRONT);
    localparam cnt_t H_SYNC_END = cnt_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam cnt_t H_LAST     = cnt_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam cnt_t V_SYNC_BEG = cnt_t'(V_ACTIVE + V_FRONT);
    localparam cnt_t V_SYNC_END = cnt_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam cnt_t V_LAST     = cnt_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);

    cnt_t h_cnt;
    cnt_t v_cnt;
    logic h_active;
    logic v_active;

    assign h_active = (h_cnt < cnt_t'(H_ACTIVE));
    assign v_active = (v_cnt < cnt_t'(V_ACTIVE));

    always_ff @(posedge clk_hdmi) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;   // wrap at end of frame
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_hdmi) begin
        if (!rst_n) begin
            vpos <= '{de: 1'b0, hs: 1'b1, vs: 1'b1, frame_start: 1'b0, x: '0, y: '0};
        end else begin
            vpos.de          <= h_active && v_active;
            vpos.hs          <= !(h_cnt >= H_SYNC_BEG && h_cnt < H_SYNC_END);
            vpos.vs          <= !(v_cnt >= V_SYNC_BEG && v_cnt < V_SYNC_END);
            vpos.frame_start <= (h_cnt == '0) && (v_cnt == '0);
            vpos.x           <= h_active ? pos_t'(h_cnt) : '0;
            vpos.y           <= v_active ? pos_t'(v_cnt) : '0;
        end
    end

endmodule
